// File: logic/alu.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module alu
    import isa_pkg::*;
    import core_pkg::*;
(
    input  word_t   a,
    input  word_t   b,
    input  alu_op_e op,
    output word_t   result
);

    always_comb begin
        case (op)
            ALU_ADD: begin
                result = a + b;
            end
            ALU_SUB: begin
                result = a - b;
            end
            ALU_AND: begin
                result = a & b;
            end
            ALU_ORR: begin
                result = a | b;
            end
            ALU_NOT: begin
                result = ~a;
            end
            ALU_TCP: begin
                result = ~a + word_t'(1);
            end
            ALU_SHL: begin
                result = {a[`WORD_SIZE-2:0], 1'b0};
            end
            ALU_SHR: begin
                result = {a[`WORD_SIZE-1], a[`WORD_SIZE-1:1]};   // sign bit is repeated
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // the decoder always produces a defined operation, even for an unknown word
    always_comb begin
        assert final (!$isunknown(op))
            else $error("alu: operation select is unknown");
    end

endmodule

// File: logic/control_unit.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module control_unit
    import isa_pkg::*;
    import core_pkg::*;
(
    input  word_t instr,
    output ctrl_t ctrl
);

    opcode_e opcode;
    func_e   func;

    assign opcode = opcode_e'(instr[`WORD_SIZE-1 -: `OPCODE_W]);
    assign func   = func_e'(instr[`FUNC_W-1:0]);

    always_comb begin
        ctrl = '0;   // anything not decoded below is a no-op
        case (opcode)
            OP_ALU: begin
                ctrl.reg_write = 1'b1;
                case (func)
                    FN_ADD:  ctrl.alu_op = ALU_ADD;
                    FN_SUB:  ctrl.alu_op = ALU_SUB;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_ORR:  ctrl.alu_op = ALU_ORR;
                    FN_NOT:  ctrl.alu_op = ALU_NOT;
                    FN_TCP:  ctrl.alu_op = ALU_TCP;
                    FN_SHL:  ctrl.alu_op = ALU_SHL;
                    FN_SHR:  ctrl.alu_op = ALU_SHR;
                    default: ctrl.reg_write = 1'b0;
                endcase
            end

            // --------------------
            // immediate forms write rt
            OP_ADI: begin
                ctrl.rt_dest   = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = ALU_ADD;
                ctrl.reg_write = 1'b1;
            end
            OP_ORI: begin
                ctrl.rt_dest   = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.imm_zext  = 1'b1;
                ctrl.alu_op    = ALU_ORR;
                ctrl.reg_write = 1'b1;
            end
            OP_LHI: begin
                ctrl.rt_dest   = 1'b1;
                ctrl.is_lhi    = 1'b1;
                ctrl.reg_write = 1'b1;
            end

            // --------------------
            // the address is rs plus the offset in both cases
            OP_LWD: begin
                ctrl.rt_dest    = 1'b1;
                ctrl.alu_src    = 1'b1;
                ctrl.alu_op     = ALU_ADD;
                ctrl.reg_write  = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
            end
            OP_SWD: begin
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = ALU_ADD;
                ctrl.mem_write = 1'b1;
            end

            OP_BNE, OP_BEQ, OP_BGZ, OP_BLZ: begin
                ctrl.branch = 1'b1;
                ctrl.alu_op = ALU_SUB;   // zero result means rs equals rt
            end

            OP_JMP: ctrl.jump = 1'b1;
            OP_JAL: begin
                ctrl.jump      = 1'b1;
                ctrl.pc_to_reg = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            OP_JPR: begin
                if (func == FN_JPR) begin
                    ctrl.jump_reg = 1'b1;
                end
            end
            OP_JRL: begin
                if (func == FN_JRL) begin
                    ctrl.jump_reg  = 1'b1;
                    ctrl.pc_to_reg = 1'b1;
                    ctrl.reg_write = 1'b1;
                end
            end
            default: ctrl = '0;
        endcase
    end

    // a store must never also update the register file
    always_comb begin
        assert final (!(ctrl.mem_write && ctrl.reg_write))
            else $error("control_unit: store decoded with register write, instr %h", instr);
    end

endmodule

// File: logic/core_pkg.sv
package core_pkg;

    // --------------------
    // operations the ALU knows, independent of the instruction encoding
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_ORR = 3'd3,
        ALU_NOT = 3'd4,   // unary, uses a only
        ALU_TCP = 3'd5,   // two's complement of a
        ALU_SHL = 3'd6,
        ALU_SHR = 3'd7    // arithmetic, keeps the sign bit
    } alu_op_e;

    // --------------------
    // decoded controls for one instruction
    typedef struct packed {
        logic    rt_dest;      // destination is rt, not rd
        logic    alu_src;      // second ALU operand is the extended immediate
        alu_op_e alu_op;
        logic    is_lhi;       // write back the immediate in the upper byte
        logic    imm_zext;     // zero-extend instead of sign-extend
        logic    reg_write;
        logic    mem_read;
        logic    mem_to_reg;
        logic    mem_write;
        logic    pc_to_reg;    // write PC+1, destination forced to the link register
        logic    jump;         // absolute target from the instruction
        logic    jump_reg;     // target taken from rs
        logic    branch;
    } ctrl_t;

endpackage

// File: logic/cpu_core.sv
`timescale 1ns/1ps

module cpu_core
    import isa_pkg::*;
    import core_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    output word_t i_addr,
    input  word_t i_data,
    output word_t d_addr,
    output word_t d_wdata,
    input  word_t d_rdata,
    output logic  d_read,
    output logic  d_write
);

    ctrl_t    ctrl;
    reg_idx_t rs_idx;
    reg_idx_t rt_idx;
    word_t    rs_data;
    word_t    rt_data;
    logic     wr_en;
    reg_idx_t wr_idx;
    word_t    wr_data;
    word_t    alu_a;
    word_t    alu_b;
    alu_op_e  alu_op;
    word_t    alu_result;

    control_unit u_control_unit (
        .instr (i_data),
        .ctrl  (ctrl)
    );

    // --------------------
    datapath u_datapath (
        .clk        (clk),
        .arst_n     (arst_n),
        .instr      (i_data),
        .ctrl       (ctrl),
        .pc         (i_addr),    // the fetch address is the PC itself
        .rs_idx     (rs_idx),
        .rt_idx     (rt_idx),
        .rs_data    (rs_data),
        .rt_data    (rt_data),
        .wr_en      (wr_en),
        .wr_idx     (wr_idx),
        .wr_data    (wr_data),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .alu_op     (alu_op),
        .alu_result (alu_result),
        .d_addr     (d_addr),
        .d_wdata    (d_wdata),
        .d_rdata    (d_rdata),
        .d_read     (d_read),
        .d_write    (d_write)
    );

    alu u_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (alu_op),
        .result (alu_result)
    );

    register_file u_register_file (
        .clk     (clk),
        .arst_n  (arst_n),
        .rs_idx  (rs_idx),
        .rt_idx  (rt_idx),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wr_en   (wr_en),
        .wr_idx  (wr_idx),
        .wr_data (wr_data)
    );

endmodule

// File: logic/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// machine word, used for both instructions and data
`define WORD_SIZE  16
`define NUM_REGS   4
`define REG_IDX_W  2
`define LINK_REG   2   // JAL and JRL leave the return address here

// --------------------
// instruction fields
`define OPCODE_W   4   // top bits of the word
`define RS_LSB     10
`define RT_LSB     8
`define RD_LSB     6
`define FUNC_W     6
`define IMM_W      8
`define TARGET_W   12

`endif

// File: logic/datapath.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module datapath
    import isa_pkg::*;
    import core_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  word_t    instr,
    input  ctrl_t    ctrl,
    output word_t    pc,
    output reg_idx_t rs_idx,
    output reg_idx_t rt_idx,
    input  word_t    rs_data,
    input  word_t    rt_data,
    output logic     wr_en,
    output reg_idx_t wr_idx,
    output word_t    wr_data,
    output word_t    alu_a,
    output word_t    alu_b,
    output alu_op_e  alu_op,
    input  word_t    alu_result,
    output word_t    d_addr,
    output word_t    d_wdata,
    input  word_t    d_rdata,
    output logic     d_read,
    output logic     d_write
);

    opcode_e  opcode;
    imm_t     imm;
    target_t  target;
    reg_idx_t rd_idx;
    word_t    pc_q;
    word_t    pc_plus1;
    word_t    pc_next;
    word_t    imm_sext;
    word_t    imm_ext;
    word_t    branch_target;
    word_t    jump_target;
    logic     branch_taken;

    assign opcode = opcode_e'(instr[`WORD_SIZE-1 -: `OPCODE_W]);
    assign imm    = instr[`IMM_W-1:0];
    assign target = instr[`TARGET_W-1:0];
    assign rs_idx = instr[`RS_LSB +: `REG_IDX_W];
    assign rt_idx = instr[`RT_LSB +: `REG_IDX_W];
    assign rd_idx = instr[`RD_LSB +: `REG_IDX_W];

    // --------------------
    // operands
    assign imm_sext = {{(`WORD_SIZE-`IMM_W){imm[`IMM_W-1]}}, imm};
    assign imm_ext  = ctrl.imm_zext ? word_t'(imm) : imm_sext;   // ORI only
    assign alu_a    = rs_data;
    assign alu_b    = ctrl.alu_src ? imm_ext : rt_data;
    assign alu_op   = ctrl.alu_op;

    // --------------------
    // program counter
    assign pc_plus1      = pc_q + word_t'(1);
    assign branch_target = pc_plus1 + imm_sext;
    assign jump_target   = {pc_q[`WORD_SIZE-1:`TARGET_W], target};

    always_comb begin
        branch_taken = 1'b0;
        if (ctrl.branch) begin
            case (opcode)
                OP_BNE:  branch_taken = (alu_result != '0);
                OP_BEQ:  branch_taken = (alu_result == '0);
                OP_BGZ:  branch_taken = ($signed(rs_data) > 0);
                OP_BLZ:  branch_taken = ($signed(rs_data) < 0);
                default: branch_taken = 1'b0;
            endcase
        end
    end

    always_comb begin
        if (ctrl.jump_reg) begin
            pc_next = rs_data;
        end else if (ctrl.jump) begin
            pc_next = jump_target;
        end else if (branch_taken) begin
            pc_next = branch_target;
        end else begin
            pc_next = pc_plus1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc_q <= '0;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign pc = pc_q;

    // --------------------
    // memory and write-back
    assign d_addr  = alu_result;
    assign d_wdata = rt_data;
    assign d_read  = ctrl.mem_read & arst_n;    // quiet while in reset
    assign d_write = ctrl.mem_write & arst_n;

    assign wr_en  = ctrl.reg_write;
    assign wr_idx = ctrl.pc_to_reg ? reg_idx_t'(`LINK_REG) : (ctrl.rt_dest ? rt_idx : rd_idx);

    always_comb begin
        if (ctrl.pc_to_reg) begin
            wr_data = pc_plus1;
        end else if (ctrl.mem_to_reg) begin
            wr_data = d_rdata;
        end else if (ctrl.is_lhi) begin
            wr_data = {imm, {(`WORD_SIZE-`IMM_W){1'b0}}};
        end else begin
            wr_data = alu_result;
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n) !(d_read && d_write))
        else $error("datapath: data read and write strobes both high");

endmodule

// File: logic/isa_pkg.sv
`include "cpu_macros.svh"

package isa_pkg;

    typedef logic [`WORD_SIZE-1:0] word_t;
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;
    typedef logic [`IMM_W-1:0]     imm_t;
    typedef logic [`TARGET_W-1:0]  target_t;

    // --------------------
    // opcodes, the top nibble of every instruction
    // register-type operations share OP_ALU and are told apart by the function code
    typedef enum logic [`OPCODE_W-1:0] {
        OP_BNE = 4'd0,
        OP_BEQ = 4'd1,
        OP_BGZ = 4'd2,
        OP_BLZ = 4'd3,
        OP_ADI = 4'd4,
        OP_ORI = 4'd5,
        OP_LHI = 4'd6,
        OP_LWD = 4'd7,
        OP_SWD = 4'd8,
        OP_JMP = 4'd9,
        OP_JAL = 4'd10,
        OP_JPR = 4'd13,   // needs FN_JPR as well
        OP_JRL = 4'd14,   // needs FN_JRL as well
        OP_ALU = 4'd15
    } opcode_e;

    // --------------------
    // function codes in the low six bits
    typedef enum logic [`FUNC_W-1:0] {
        FN_ADD = 6'd0,
        FN_SUB = 6'd1,
        FN_AND = 6'd2,
        FN_ORR = 6'd3,
        FN_NOT = 6'd4,
        FN_TCP = 6'd5,
        FN_SHL = 6'd6,
        FN_SHR = 6'd7,
        FN_JPR = 6'd25,
        FN_JRL = 6'd26
    } func_e;

endpackage

// File: logic/register_file.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module register_file
    import isa_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  reg_idx_t rs_idx,
    input  reg_idx_t rt_idx,
    output word_t    rs_data,
    output word_t    rt_data,
    input  logic     wr_en,
    input  reg_idx_t wr_idx,
    input  word_t    wr_data
);

    word_t regs [`NUM_REGS];

    // --------------------
    // write port
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // reads are combinational, a write shows up after the edge
    assign rs_data = regs[rs_idx];
    assign rt_data = regs[rt_idx];

    // --------------------
    // an unknown index would corrupt an arbitrary register
    assert property (@(posedge clk) disable iff (!arst_n)
        wr_en |-> !$isunknown(wr_idx))
        else $error("register_file: write with unknown index");

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# compile the core and its testbench with Verilator, run it and check the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f vlog.f \
    --top-module cpu_core_tb \
    -o cpu_core_sim

# the pipeline status is that of tee, so a failing run still reaches the log check
./obj_dir/cpu_core_sim 2>&1 | tee sim.log

if grep -qx "Everything OK" sim.log; then
    echo "PASS"
else
    echo "FAIL: see sim.log"
    exit 1
fi

// File: verification/cpu_core_tb.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_core_tb
    import isa_pkg::*;
();

    localparam int    MEM_DEPTH = 256;
    localparam int    VEC_DEPTH = 2 + MEM_DEPTH + 2 * MEM_DEPTH;
    localparam string VEC_FILE  = "verification/cpu_vectors.hex";

    logic  clk = 1'b0;
    logic  arst_n;
    word_t i_addr;
    word_t i_data = '0;
    word_t d_addr;
    word_t d_wdata;
    word_t d_rdata = '0;
    logic  d_read;
    logic  d_write;

    // length, store count, program words, then address and data of each store
    logic [`WORD_SIZE-1:0] vec_mem [VEC_DEPTH];
    word_t imem [MEM_DEPTH];
    word_t dmem [MEM_DEPTH];

    logic vectors_loaded = 1'b0;
    int   prog_len;
    int   store_count;
    int   pair_base;
    int   stores_seen = 0;
    int   cycle_count = 0;
    int   timeout_limit;

    cpu_core u_dut (
        .clk     (clk),
        .arst_n  (arst_n),
        .i_addr  (i_addr),
        .i_data  (i_data),
        .d_addr  (d_addr),
        .d_wdata (d_wdata),
        .d_rdata (d_rdata),
        .d_read  (d_read),
        .d_write (d_write)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // --------------------
    // reporting
    task automatic fail_and_stop();
        $display("Something failed");
        $fatal(1, "simulation stopped at %0t ns", $time);
    endtask

    task automatic check_word(input string name, input word_t actual, input word_t expected);
        assert (actual === expected)
            else begin
                $display("FAILED at %0t ns: %s is %h, expected %h",
                         $time, name, actual, expected);
                fail_and_stop();
            end
    endtask

    // stores must show up in program order and a poisoned one fails on its address
    task automatic check_store();
        assert (stores_seen < store_count)
            else begin
                $display("ERROR: store to address %h after all expected stores", d_addr);
                fail_and_stop();
            end
        check_word("d_addr", d_addr, vec_mem[pair_base + 2 * stores_seen]);
        check_word("d_wdata", d_wdata, vec_mem[pair_base + 2 * stores_seen + 1]);
        dmem[d_addr[7:0]] = d_wdata;
        stores_seen++;
    endtask

    // --------------------
    // memory models drive both read ports shortly after each edge
    initial begin
        void'($urandom(16));
        $readmemh(VEC_FILE, vec_mem);
        prog_len    = int'(vec_mem[0]);
        store_count = int'(vec_mem[1]);
        pair_base   = 2 + prog_len;
        for (int i = 0; i < MEM_DEPTH; i++) begin
            if (i < prog_len) begin
                imem[i] = vec_mem[2 + i];
            end else begin
                imem[i] = word_t'(32'h9000 | i);   // a JMP to its own address
            end
            dmem[i] = word_t'($urandom());
        end
        vectors_loaded = 1'b1;

        forever begin
            @(posedge clk);
            // only a load out of reset may strobe the data read
            check_word("d_read", word_t'(d_read),
                       word_t'(arst_n && i_data[`WORD_SIZE-1 -: `OPCODE_W] == OP_LWD));
            if (arst_n && d_write) begin
                check_store();
            end
            #1;
            i_data = imem[i_addr[7:0]];
            #1;
            d_rdata = dmem[d_addr[7:0]];   // the address comes from the new instruction
        end
    end

    // --------------------
    // hold reset and run until every expected store has been seen
    initial begin
        arst_n = 1'b0;
        wait (vectors_loaded);
        assert (prog_len > 0 && prog_len <= MEM_DEPTH && store_count > 0)
            else begin
                $display("ERROR: %s has no usable program length or store count", VEC_FILE);
                fail_and_stop();
            end
        timeout_limit = 4 * prog_len + 50;

        repeat (2) @(posedge clk);
        check_word("i_addr", i_addr, '0);
        check_word("d_write", word_t'(d_write), '0);
        #1;
        arst_n = 1'b1;

        wait (stores_seen == store_count || cycle_count >= timeout_limit);
        if (stores_seen == store_count) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("ERROR: timeout after %0d cycles with %0d of %0d stores seen",
                     cycle_count, stores_seen, store_count);
            fail_and_stop();
        end
    end

endmodule

// File: verification/cpu_vectors.hex
// first line: program length, expected store count
// then the program words from address 0, then one address and data pair per store
0033 000F
// ALU functions, then load and store again, then branches, then jumps
6112 55F0 4385 F780 8210 F781 8211 F782
8212 F783 8213 F784 8214 F785 8215 F786
8216 FD87 8217 4330 7DE0 8D08 0701 8120
0501 8121 1501 8122 1701 8123 2401 8124
2001 8125 3801 8126 3001 8127 A028 81F0
8230 902B 81F1 432E DC19 81F2 4331 EC1A
81F3 8231 9032
// ADD SUB AND ORR, then NOT TCP SHL SHR
0010 1275  0011 136B  0012 1280  0013 FFF5
0014 ED0F  0015 ED10  0016 25E0  0017 FFC2
// word loaded from 0x30-0x20 and stored at 0x30+0x08
0038 1275
// markers of the branches that are not taken
0021 1275  0023 1275  0025 1275  0027 1275
// link values written by JAL and JRL
0030 0027  0031 0030

// File: vlog.f
+incdir+logic
logic/isa_pkg.sv
logic/core_pkg.sv
logic/control_unit.sv
logic/alu.sv
logic/register_file.sv
logic/datapath.sv
logic/cpu_core.sv
verification/cpu_core_tb.sv
